//--- dv/fft8_patterns.txt
// per frame: samples 0..7 as {re,im} 12 bits each, then bins 0..7 as {re,im} 16 bits each
// frames: impulse, constant, odd impulse, mixed, alternating sign, negative full scale
064FCE 000000 000000 000000 000000 000000 000000 000000 0064FFCE 0064FFCE 0064FFCE 0064FFCE 0064FFCE 0064FFCE 0064FFCE 0064FFCE
0C801E 0C801E 0C801E 0C801E 0C801E 0C801E 0C801E 0C801E 064000F0 00000000 00000000 00000000 00000000 00000000 00000000 00000000
000000 3E8000 000000 000000 000000 000000 000000 000000 03E80000 02C3FD3C 0000FC18 FD3CFD3C FC180000 FD3D02C4 000003E8 02C402C4
12C000 000000 000000 000190 000000 000000 000000 000000 012C0190 0246FEE5 FF9C0000 0246011A 012CFE70 0012011B 02BC0000 0012FEE6
064000 F9C000 064000 F9C000 064000 F9C000 064000 F9C000 00000000 00000000 00000000 00000000 03200000 00000000 00000000 00000000
000000 800800 000000 000000 000000 000000 000000 000000 F800F800 F4AF0000 F8000800 00000B50 08000800 0B510000 0800F800 0000F4B0

//--- verilog.f
+incdir+verilog
verilog/fft8_pkg.sv
verilog/fft8_sample_router.sv
verilog/dft4_accumulator.sv
verilog/radix2_combiner.sv
verilog/fft8_result_streamer.sv
verilog/fft8_top.sv
dv/fft8_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -Wno-fatal
TOP      := fft8_tb
FILELIST := verilog.f
OBJ_DIR  := obj_dir

.PHONY: sim clean

# build and run, exit status follows the testbench
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/fft8_tb.sv
`include "fft8_params.svh"

module fft8_tb;

    localparam int NUM_FRAMES = 6;
    // eight sample words, then eight expected bin words
    localparam int WORDS_PER_FRAME = 2 * `FFT8_POINTS;
    localparam int TIMEOUT = 100;
    // last sample edge to first bin, 4 issues + mul stage + done pulse
    localparam int FIRST_BIN_LATENCY = 6;

    logic              clk;
    logic              reset;
    logic              sample_valid_i;
    fft8_pkg::sample_t sample_i;
    logic              accept_o;
    logic              out_ready_i;
    logic              out_valid_o;
    fft8_pkg::bin_t    bin_o;
    logic              complete_o;

    // frames from the pattern file
    logic [31:0] pat_mem [NUM_FRAMES * WORDS_PER_FRAME];
    integer      seed;

    fft8_top dut_i
    (
        .clk            (clk),
        .reset          (reset),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .accept_o       (accept_o),
        .out_ready_i    (out_ready_i),
        .out_valid_o    (out_valid_o),
        .bin_o          (bin_o),
        .complete_o     (complete_o)
    );

    // 40 unit period
    always #20 clk = ~clk;

    ////////////////////
    // compare helpers
    ////////////////////

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "simulation stopped");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: gave up waiting for %s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    // random data on the sample bus, valid only when junk is wanted
    task automatic drive_idle(input bit junk);
        logic [31:0] rnd;
        rnd = $random(seed);
        sample_valid_i = junk;
        sample_i       = rnd[23:0];
    endtask

    // eight samples, random gaps in random mode
    task automatic send_frame(input int f, input bit rand_mode);
        int          n;
        int          waited;
        logic [31:0] rnd;
        n      = 0;
        waited = 0;
        while (n < `FFT8_POINTS)
        begin
            @(negedge clk);
            rnd = $random(seed);
            if (rand_mode && rnd[1:0] == 2'd0)
                drive_idle(1'b0);
            else
            begin
                sample_valid_i = 1'b1;
                sample_i       = pat_mem[f * WORDS_PER_FRAME + n][23:0];
                // taken on the coming rising edge
                if (accept_o)
                    n++;
            end
            waited++;
            if (waited > TIMEOUT)
                stop_on_timeout("all eight samples to be accepted");
        end
    endtask

    ////////////////////
    // output checker
    ////////////////////

    // bins 0..7 in order, checked before the consuming edge
    task automatic receive_frame(input int f, input bit rand_mode, input bit junk);
        int             idx;
        int             waited;
        int             latency;
        logic           seen_valid;
        logic           stalled;
        fft8_pkg::bin_t held;
        logic [31:0]    rnd;
        idx        = 0;
        waited     = 0;
        latency    = 0;
        seen_valid = 1'b0;
        stalled    = 1'b0;
        while (idx < `FFT8_POINTS)
        begin
            @(negedge clk);
            drive_idle(junk);
            rnd         = $random(seed);
            out_ready_i = rand_mode ? rnd[0] : 1'b1;
            // one frame in flight, junk must not get in
            check_equal(accept_o, 1'b0, "accept_o low while frame in flight");
            if (!out_valid_o)
            begin
                if (!seen_valid)
                    latency++;
            end
            else
            begin
                if (!seen_valid)
                    check_equal(latency, FIRST_BIN_LATENCY, "cycles to first bin");
                seen_valid = 1'b1;
                if (stalled)
                    check_equal(bin_o, held, "bin_o held while ready low");
                check_equal(complete_o, 1'b1, "complete_o while out_valid_o");
                check_equal(bin_o, pat_mem[f * WORDS_PER_FRAME + `FFT8_POINTS + idx],
                            $sformatf("frame %0d bin %0d", f, idx));
                stalled = !out_ready_i;
                held    = bin_o;
                if (out_ready_i)
                    idx++;
            end
            waited++;
            if (waited > TIMEOUT)
                stop_on_timeout("all eight bins to be consumed");
        end
    endtask

    // accept comes back one cycle after the edge that took bin 7
    task automatic wait_accept();
        int waited;
        waited = 0;
        do
        begin
            @(negedge clk);
            drive_idle(1'b0);
            waited++;
            if (waited > TIMEOUT)
                stop_on_timeout("accept_o after the last bin");
        end
        while (!accept_o);
        check_equal(waited, 2, "cycles from last bin to accept_o");
        check_equal(out_valid_o, 1'b0, "out_valid_o after last bin");
        check_equal(complete_o, 1'b0, "complete_o after last bin");
    endtask

    task automatic run_frame(input int f, input bit rand_mode, input bit junk);
        send_frame(f, rand_mode);
        receive_frame(f, rand_mode, junk);
        wait_accept();
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial
    begin
        seed           = 32'h1862;
        clk            = 1'b0;
        reset          = 1'b1;
        sample_valid_i = 1'b0;
        sample_i       = '0;
        out_ready_i    = 1'b0;
        $readmemh("dv/fft8_patterns.txt", pat_mem);

        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_equal(accept_o, 1'b1, "accept_o after reset");
        check_equal(out_valid_o, 1'b0, "out_valid_o after reset");
        check_equal(complete_o, 1'b0, "complete_o after reset");

        // ready held high, no gaps
        for (int f = 0; f < NUM_FRAMES; f++)
            run_frame(f, 1'b0, 1'b0);
        // random ready and input gaps
        for (int f = 0; f < NUM_FRAMES; f++)
            run_frame(f, 1'b1, 1'b0);
        // same, plus junk offered while accept is low
        for (int f = 0; f < NUM_FRAMES; f++)
            run_frame(f, 1'b1, 1'b1);

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- verilog/fft8_top.sv
module fft8_top
(
    input  logic              clk,
    input  logic              reset,
    input  logic              sample_valid_i,
    input  fft8_pkg::sample_t sample_i,
    output logic              accept_o,
    input  logic              out_ready_i,
    output logic              out_valid_o,
    output fft8_pkg::bin_t    bin_o,
    output logic              complete_o
);

    // router to kernels
    logic               even_take;
    logic               odd_take;
    fft8_pkg::sample_t  route_sample;

    // kernels to combiner
    logic               even_done;
    logic               odd_done;
    fft8_pkg::bin_t     even_bin;
    fft8_pkg::bin_t     odd_bin;
    fft8_pkg::bin_idx_t kern_sel;
    logic               kern_clear;

    // combiner to streamer
    logic               wr_en;
    logic [2:0]         wr_idx;
    fft8_pkg::bin_t     wr_lo;
    fft8_pkg::bin_t     wr_hi;
    logic               frame_done;

    // streamer back to router
    logic               frame_sent;

    ////////////////////
    // input side
    ////////////////////

    fft8_sample_router router_i
    (
        .clk            (clk),
        .reset          (reset),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .frame_sent_i   (frame_sent),
        .accept_o       (accept_o),
        .even_take_o    (even_take),
        .odd_take_o     (odd_take),
        .route_sample_o (route_sample)
    );

    ////////////////////
    // processing
    ////////////////////

    // samples 0, 2, 4, 6
    dft4_accumulator even_dft_i
    (
        .clk      (clk),
        .reset    (reset),
        .take_i   (even_take),
        .sample_i (route_sample),
        .clear_i  (kern_clear),
        .sel_i    (kern_sel),
        .done_o   (even_done),
        .bin_o    (even_bin)
    );

    // samples 1, 3, 5, 7
    dft4_accumulator odd_dft_i
    (
        .clk      (clk),
        .reset    (reset),
        .take_i   (odd_take),
        .sample_i (route_sample),
        .clear_i  (kern_clear),
        .sel_i    (kern_sel),
        .done_o   (odd_done),
        .bin_o    (odd_bin)
    );

    radix2_combiner combiner_i
    (
        .clk          (clk),
        .reset        (reset),
        .even_done_i  (even_done),
        .odd_done_i   (odd_done),
        .even_bin_i   (even_bin),
        .odd_bin_i    (odd_bin),
        .sel_o        (kern_sel),
        .clear_o      (kern_clear),
        .wr_en_o      (wr_en),
        .wr_idx_o     (wr_idx),
        .wr_lo_o      (wr_lo),
        .wr_hi_o      (wr_hi),
        .frame_done_o (frame_done)
    );

    ////////////////////
    // output side
    ////////////////////

    fft8_result_streamer streamer_i
    (
        .clk          (clk),
        .reset        (reset),
        .wr_en_i      (wr_en),
        .wr_idx_i     (wr_idx),
        .wr_lo_i      (wr_lo),
        .wr_hi_i      (wr_hi),
        .frame_done_i (frame_done),
        .out_ready_i  (out_ready_i),
        .out_valid_o  (out_valid_o),
        .complete_o   (complete_o),
        .bin_o        (bin_o),
        .frame_sent_o (frame_sent)
    );

endmodule

//--- verilog/fft8_result_streamer.sv
`include "fft8_params.svh"

module fft8_result_streamer
(
    input  logic           clk,
    input  logic           reset,
    input  logic           wr_en_i,
    input  logic [2:0]     wr_idx_i,
    input  fft8_pkg::bin_t wr_lo_i,
    input  fft8_pkg::bin_t wr_hi_i,
    input  logic           frame_done_i,
    input  logic           out_ready_i,
    output logic           out_valid_o,
    output logic           complete_o,
    output fft8_pkg::bin_t bin_o,
    output logic           frame_sent_o
);

    localparam int IDX_W = $clog2(`FFT8_POINTS);
    localparam logic [IDX_W-1:0] HALF = IDX_W'(`FFT8_POINTS / 2);
    localparam logic [IDX_W-1:0] LAST = IDX_W'(`FFT8_POINTS - 1);

    // result buffer, bins 0..7
    fft8_pkg::bin_t   bin_buf [`FFT8_POINTS];
    // index of the bin on bin_o
    logic [IDX_W-1:0] send_cnt;
    logic [IDX_W-1:0] next_idx;
    logic             consume;

    assign consume  = out_valid_o & out_ready_i;
    assign next_idx = send_cnt + 1'b1;

    ////////////////////
    // buffer writes
    ////////////////////

    // low half at k, high half at k+4
    always_ff @(posedge clk)
    begin
        if (wr_en_i)
        begin
            bin_buf[wr_idx_i]        <= wr_lo_i;
            bin_buf[wr_idx_i + HALF] <= wr_hi_i;
        end
    end

    ////////////////////
    // output sequencer
    ////////////////////

    // output register moves only on a consumed bin
    always_ff @(posedge clk)
    begin
        if (frame_done_i)
            bin_o <= bin_buf[0];
        else if (consume)
            bin_o <= bin_buf[next_idx];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid_o  <= 1'b0;
            complete_o   <= 1'b0;
            frame_sent_o <= 1'b0;
            send_cnt     <= '0;
        end
        else
        begin
            frame_sent_o <= consume & (send_cnt == LAST);
            // frame is held from its first write on
            if (wr_en_i)
                complete_o <= 1'b1;
            if (frame_done_i)
            begin
                out_valid_o <= 1'b1;
                send_cnt    <= '0;
            end
            else if (consume)
            begin
                send_cnt <= next_idx;
                // bin 7 gone, frame fully sent
                if (send_cnt == LAST)
                begin
                    out_valid_o <= 1'b0;
                    complete_o  <= 1'b0;
                end
            end
        end
    end

endmodule

//--- verilog/radix2_combiner.sv
`include "fft8_params.svh"

module radix2_combiner
(
    input  logic               clk,
    input  logic               reset,
    input  logic               even_done_i,
    input  logic               odd_done_i,
    input  fft8_pkg::bin_t     even_bin_i,
    input  fft8_pkg::bin_t     odd_bin_i,
    output fft8_pkg::bin_idx_t sel_o,
    output logic               clear_o,
    output logic               wr_en_o,
    output logic [2:0]         wr_idx_o,
    output fft8_pkg::bin_t     wr_lo_o,
    output fft8_pkg::bin_t     wr_hi_o,
    output logic               frame_done_o
);

    localparam logic signed [`FFT8_BIN_W:0] TW_C = `FFT8_TWIDDLE_C;
    localparam int PROD_W = 2 * `FFT8_BIN_W + 2;

    // issue sequencer
    logic               busy;
    fft8_pkg::bin_idx_t k_cnt;
    logic               start;
    logic               issue;

    // odd term sums and scaled products
    logic signed [`FFT8_BIN_W:0] o_sum;
    logic signed [`FFT8_BIN_W:0] o_diff;
    logic signed [PROD_W-1:0]    p_sum;
    logic signed [PROD_W-1:0]    p_nsum;
    logic signed [PROD_W-1:0]    p_diff;
    fft8_pkg::bin_t              twid;

    // multiply register stage
    logic               mul_vld;
    fft8_pkg::bin_idx_t mul_k;
    fft8_pkg::bin_t     even_r;
    fft8_pkg::bin_t     twid_r;

    ////////////////////
    // issue k = 0..3
    ////////////////////

    // clear_o high blocks a restart while done is still falling
    assign start = even_done_i & odd_done_i & ~busy & ~clear_o;
    assign issue = start | busy;
    assign sel_o = k_cnt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy    <= 1'b0;
            k_cnt   <= '0;
            clear_o <= 1'b0;
        end
        else
        begin
            clear_o <= issue & (k_cnt == 2'd3);
            if (issue)
            begin
                k_cnt <= k_cnt + 1'b1;
                busy  <= (k_cnt != 2'd3);
            end
        end
    end

    ////////////////////
    // twiddle multiply
    ////////////////////

    // sums first, then one multiply each
    always_comb
    begin
        o_sum  = odd_bin_i.re + odd_bin_i.im;
        o_diff = odd_bin_i.im - odd_bin_i.re;
        p_sum  = (o_sum * TW_C) >>> `FFT8_TWIDDLE_SHIFT;
        p_nsum = (-(o_sum * TW_C)) >>> `FFT8_TWIDDLE_SHIFT;
        p_diff = (o_diff * TW_C) >>> `FFT8_TWIDDLE_SHIFT;
        case (k_cnt)
            2'd0:
                twid = odd_bin_i;
            2'd1:
            begin
                twid.re = p_sum[`FFT8_BIN_W-1:0];
                twid.im = p_diff[`FFT8_BIN_W-1:0];
            end
            2'd2:
            begin
                // W^2 is -j, no multiply
                twid.re = odd_bin_i.im;
                twid.im = -odd_bin_i.re;
            end
            default:
            begin
                twid.re = p_diff[`FFT8_BIN_W-1:0];
                twid.im = p_nsum[`FFT8_BIN_W-1:0];
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mul_vld      <= 1'b0;
            mul_k        <= '0;
            frame_done_o <= 1'b0;
        end
        else
        begin
            mul_vld      <= issue;
            mul_k        <= k_cnt;
            // one cycle after the last pair is written
            frame_done_o <= mul_vld & (mul_k == 2'd3);
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            even_r <= even_bin_i;
            twid_r <= twid;
        end
    end

    ////////////////////
    // butterfly
    ////////////////////

    // X[k] and X[k+4] in one write
    always_comb
    begin
        wr_lo_o.re = even_r.re + twid_r.re;
        wr_lo_o.im = even_r.im + twid_r.im;
        wr_hi_o.re = even_r.re - twid_r.re;
        wr_hi_o.im = even_r.im - twid_r.im;
    end

    assign wr_en_o  = mul_vld;
    assign wr_idx_o = {1'b0, mul_k};

endmodule

//--- verilog/dft4_accumulator.sv
`include "fft8_params.svh"

module dft4_accumulator
(
    input  logic               clk,
    input  logic               reset,
    input  logic               take_i,
    input  fft8_pkg::sample_t  sample_i,
    input  logic               clear_i,
    input  fft8_pkg::bin_idx_t sel_i,
    output logic               done_o,
    output fft8_pkg::bin_t     bin_o
);

    // running sums, one per 4 point bin
    fft8_pkg::bin_t     acc [4];
    // per bin term for the current sample
    fft8_pkg::bin_t     term [4];
    // sample index n inside the kernel
    fft8_pkg::bin_idx_t n_cnt;

    // x times (-j)^p, only swaps and negations
    function automatic fft8_pkg::bin_t rotate(input fft8_pkg::sample_t  x,
                                              input fft8_pkg::bin_idx_t p);
        fft8_pkg::bin_t                r;
        logic signed [`FFT8_BIN_W-1:0] xr;
        logic signed [`FFT8_BIN_W-1:0] xi;
        // widen before negating
        xr = x.re;
        xi = x.im;
        case (p)
            2'd0:
            begin
                r.re = xr;
                r.im = xi;
            end
            2'd1:
            begin
                // times -j
                r.re = xi;
                r.im = -xr;
            end
            2'd2:
            begin
                r.re = -xr;
                r.im = -xi;
            end
            default:
            begin
                // times +j
                r.re = -xi;
                r.im = xr;
            end
        endcase
        return r;
    endfunction

    ////////////////////
    // twiddle per bin
    ////////////////////

    // exponent n*k taken mod 4
    always_comb
    begin
        for (int k = 0; k < 4; k++)
            term[k] = rotate(sample_i, fft8_pkg::bin_idx_t'(int'(n_cnt) * k));
    end

    // first sample loads, later ones add
    always_ff @(posedge clk)
    begin
        if (take_i)
        begin
            for (int k = 0; k < 4; k++)
            begin
                if (n_cnt == 2'd0)
                    acc[k] <= term[k];
                else
                begin
                    acc[k].re <= acc[k].re + term[k].re;
                    acc[k].im <= acc[k].im + term[k].im;
                end
            end
        end
    end

    // sample count and done level
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            n_cnt  <= '0;
            done_o <= 1'b0;
        end
        else
        begin
            if (clear_i)
                done_o <= 1'b0;
            if (take_i)
            begin
                n_cnt <= n_cnt + 1'b1;
                if (n_cnt == 2'd3)
                    done_o <= 1'b1;
            end
        end
    end

    // combiner read port
    assign bin_o = acc[sel_i];

endmodule

//--- verilog/fft8_sample_router.sv
`include "fft8_params.svh"

module fft8_sample_router
(
    input  logic              clk,
    input  logic              reset,
    input  logic              sample_valid_i,
    input  fft8_pkg::sample_t sample_i,
    input  logic              frame_sent_i,
    output logic              accept_o,
    output logic              even_take_o,
    output logic              odd_take_o,
    output fft8_pkg::sample_t route_sample_o
);

    localparam int CNT_W = $clog2(`FFT8_POINTS);

    // index of the next sample in the frame
    logic [CNT_W-1:0] sample_cnt;
    logic             accepted;
    logic             last_sample;

    // sample counts only while accept is up
    assign accepted    = sample_valid_i & accept_o;
    assign last_sample = (sample_cnt == CNT_W'(`FFT8_POINTS - 1));

    ////////////////////
    // even/odd steering
    ////////////////////

    // count parity picks the kernel
    assign even_take_o    = accepted & ~sample_cnt[0];
    assign odd_take_o     = accepted & sample_cnt[0];
    // both kernels see the same bus, take qualifies it
    assign route_sample_o = sample_i;

    ////////////////////
    // accept level
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sample_cnt <= '0;
            accept_o   <= 1'b1;
        end
        else
        begin
            if (accepted)
            begin
                // wraps to zero after the eighth sample
                sample_cnt <= sample_cnt + 1'b1;
                // drop accept on the same edge as sample 7
                if (last_sample)
                    accept_o <= 1'b0;
            end
            // one frame in flight, reopen after output drained
            if (frame_sent_i)
                accept_o <= 1'b1;
        end
    end

endmodule

//--- verilog/fft8_pkg.sv
`include "fft8_params.svh"

package fft8_pkg;

    ////////////////////
    // complex types
    ////////////////////

    // one complex input sample
    typedef struct packed {
        // real part
        logic signed [`FFT8_SAMPLE_W-1:0] re;
        // imaginary part
        logic signed [`FFT8_SAMPLE_W-1:0] im;
    } sample_t;

    // kernel result and final bin share one shape
    typedef struct packed {
        // real part
        logic signed [`FFT8_BIN_W-1:0] re;
        // imaginary part
        logic signed [`FFT8_BIN_W-1:0] im;
    } bin_t;

    ////////////////////
    // indices
    ////////////////////

    // bin index inside a 4 point kernel
    typedef logic [1:0] bin_idx_t;

endpackage

//--- verilog/fft8_params.svh
`ifndef FFT8_PARAMS_SVH
`define FFT8_PARAMS_SVH

////////////////////
// transform size
////////////////////

// points per frame, fixed
`define FFT8_POINTS 8

////////////////////
// data widths
////////////////////

// signed input component
`define FFT8_SAMPLE_W 12

// signed kernel result and bin component
// 12 bits plus growth for 8 summed terms
`define FFT8_BIN_W 16

////////////////////
// twiddle
////////////////////

// 1/sqrt(2) in q15
`define FFT8_TWIDDLE_C 23170
// shift back after the q15 multiply
`define FFT8_TWIDDLE_SHIFT 15

`endif
